/* common/lo_pair_if.sv */
`timescale 1ns/1ns

// Two LO phases per clock, one for each DDR half
interface lo_pair_if;

	// First half of the DAC clock
	upconv_pkg::sample_t cos1;
	upconv_pkg::sample_t sin1;
	// Second half of the DAC clock
	upconv_pkg::sample_t cos2;
	upconv_pkg::sample_t sin2;

	// LO generators
	modport src (output cos1, sin1, cos2, sin2);
	// Level mixers
	modport dst (input cos1, sin1, cos2, sin2);

endinterface

/* common/seq_pkg.sv */
package seq_pkg;

	// Division phase, value equals the 2-bit divider state
	typedef enum logic [1:0] {
		PH0 = 2'd0,
		PH1 = 2'd1,
		PH2 = 2'd2,
		PH3 = 2'd3
	} div_phase_e;

	// Table runs 0..32, period 33, 14 cycles per period (40 MHz image)
	localparam int  LUT_LAST = 32;
	localparam int  LUT_STEP = 14;
	localparam real TWO_PI   = 6.283185307179586;

	// Input to DAC latency, mute spans one full pipeline flush
	localparam int PIPE_LAT     = 4;
	localparam int FLUSH_CYCLES = PIPE_LAT;

endpackage

/* common/upconv_pkg.sv */
package upconv_pkg;

	// Sample widths
	localparam int SAMPLE_W = 18;
	localparam int IQ_W     = 17;
	localparam int DAC_W    = 16;

	// LO and drive samples, full-rate I/Q, DAC words
	typedef logic signed [SAMPLE_W-1:0] sample_t;
	typedef logic signed [IQ_W-1:0]     iq_t;
	typedef logic signed [DAC_W-1:0]    dac_t;

	// LO path select, 0 is the rotated 145 MHz LO
	typedef enum logic {
		LO_145 = 1'b0,
		LO_60  = 1'b1
	} lo_mode_e;

	// Mixer output scaling and symmetric saturation limits
	localparam int MIX_SHIFT = 17;
	localparam int DAC_MAX   = 2**(DAC_W-1) - 1;
	localparam int DAC_MIN   = -DAC_MAX;

	// Table phasor amplitude and the shift that brings products back to 18 bits
	localparam int LUT_AMP    = 2**(SAMPLE_W-1) - 1;
	localparam int LO_SHIFT   = SAMPLE_W - 1;
	localparam int SAMPLE_MAX = 2**(SAMPLE_W-1) - 1;
	localparam int SAMPLE_MIN = -(2**(SAMPLE_W-1));

endpackage

/* lo_gen/quarter_lo_rotator.sv */
`timescale 1ns/1ns

module quarter_lo_rotator (
	input  logic                clk,
	input  logic                i_rst_n,
	input  seq_pkg::div_phase_e i_phase,
	input  upconv_pkg::sample_t i_cosa,
	input  upconv_pkg::sample_t i_sina,
	lo_pair_if.src              lo
);

	upconv_pkg::sample_t cos_b;
	upconv_pkg::sample_t sin_b;

	// ------------------------------------------------------------
	// Stage 1: multiply by j^phase, quarter-rate LO
	// ------------------------------------------------------------
	// Negation by one's complement, off by one LSB and no adder
	always_ff @(posedge clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			cos_b <= '0;
			sin_b <= '0;
		end else begin
			unique case (i_phase)
				seq_pkg::PH0: begin
					cos_b <= i_cosa;
					sin_b <= i_sina;
				end
				seq_pkg::PH1: begin
					cos_b <= ~i_sina;
					sin_b <= i_cosa;
				end
				seq_pkg::PH2: begin
					cos_b <= ~i_cosa;
					sin_b <= ~i_sina;
				end
				seq_pkg::PH3: begin
					cos_b <= i_sina;
					sin_b <= ~i_cosa;
				end
			endcase
		end
	end

	// ------------------------------------------------------------
	// Stage 2: interpolate the two DDR halves
	// ------------------------------------------------------------
	// 1/16 stands in for the small phase step between halves
	always_ff @(posedge clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			lo.cos1 <= '0;
			lo.sin1 <= '0;
			lo.cos2 <= '0;
			lo.sin2 <= '0;
		end else begin
			// Times 1+j/16
			lo.cos1 <= cos_b - (sin_b >>> 4);
			lo.sin1 <= sin_b + (cos_b >>> 4);
			// Times j+1/16
			lo.cos2 <= ~sin_b + (cos_b >>> 4);
			lo.sin2 <= cos_b + (sin_b >>> 4);
		end
	end

endmodule

/* lo_gen/table_lo_mixer.sv */
`timescale 1ns/1ns

module table_lo_mixer (
	input  logic                clk,
	input  logic                i_rst_n,
	input  logic [5:0]          i_lut_addr,
	input  upconv_pkg::sample_t i_cosa,
	input  upconv_pkg::sample_t i_sina,
	lo_pair_if.src              lo
);

	localparam int LUT_N = seq_pkg::LUT_LAST + 1;

	// Table entry for one DDR half
	// Half 1 sits half a sample later
	function automatic upconv_pkg::sample_t tab_value(input int half, input int k,
	                                                  input bit want_sin);
		real ang;
		real v;
		ang = seq_pkg::TWO_PI * real'(seq_pkg::LUT_STEP) * (real'(k) + 0.5 * real'(half))
		      / real'(LUT_N);
		v = want_sin ? $sin(ang) : $cos(ang);
		v = v * real'(upconv_pkg::LUT_AMP);
		return upconv_pkg::sample_t'($rtoi((v >= 0.0) ? v + 0.5 : v - 0.5));
	endfunction

	// Scale a product sum back to 18 bits and clip
	function automatic upconv_pkg::sample_t sat_sample(input logic signed [36:0] x);
		logic signed [19:0] s;
		s = 20'(x >>> upconv_pkg::LO_SHIFT);
		if (s > upconv_pkg::SAMPLE_MAX)
			return upconv_pkg::sample_t'(upconv_pkg::SAMPLE_MAX);
		else if (s < upconv_pkg::SAMPLE_MIN)
			return upconv_pkg::sample_t'(upconv_pkg::SAMPLE_MIN);
		return upconv_pkg::sample_t'(s);
	endfunction

	upconv_pkg::sample_t cos_tab [2][LUT_N];
	upconv_pkg::sample_t sin_tab [2][LUT_N];
	upconv_pkg::sample_t cos_rd  [2];
	upconv_pkg::sample_t sin_rd  [2];
	upconv_pkg::sample_t lo_c;
	upconv_pkg::sample_t lo_s;
	logic signed [36:0]  re_full [2];
	logic signed [36:0]  im_full [2];

	// ------------------------------------------------------------
	// ROM contents fixed at elaboration
	// ------------------------------------------------------------
	for (genvar h = 0; h < 2; h++) begin : g_half
		for (genvar k = 0; k < LUT_N; k++) begin : g_entry
			localparam upconv_pkg::sample_t COS_V = tab_value(h, k, 1'b0);
			localparam upconv_pkg::sample_t SIN_V = tab_value(h, k, 1'b1);
			assign cos_tab[h][k] = COS_V;
			assign sin_tab[h][k] = SIN_V;
		end
	end

	// Stage 1 reads both tables and delays the LO to match
	always_ff @(posedge clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			cos_rd <= '{default: '0};
			sin_rd <= '{default: '0};
			lo_c   <= '0;
			lo_s   <= '0;
		end else begin
			for (int h = 0; h < 2; h++) begin
				cos_rd[h] <= cos_tab[h][i_lut_addr];
				sin_rd[h] <= sin_tab[h][i_lut_addr];
			end
			lo_c <= i_cosa;
			lo_s <= i_sina;
		end
	end

	// Table phasor times input LO
	always_comb begin
		for (int h = 0; h < 2; h++) begin
			re_full[h] = cos_rd[h] * lo_c - sin_rd[h] * lo_s;
			im_full[h] = cos_rd[h] * lo_s + sin_rd[h] * lo_c;
		end
	end

	// Stage 2 registers the scaled products
	always_ff @(posedge clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			lo.cos1 <= '0;
			lo.sin1 <= '0;
			lo.cos2 <= '0;
			lo.sin2 <= '0;
		end else begin
			lo.cos1 <= sat_sample(re_full[0]);
			lo.sin1 <= sat_sample(im_full[0]);
			lo.cos2 <= sat_sample(re_full[1]);
			lo.sin2 <= sat_sample(im_full[1]);
		end
	end

endmodule

/* run_sim.sh */
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -Wno-fatal -f second_if_out.f \
	--top-module second_if_out_tb -o second_if_out_sim
out=$(./obj_dir/second_if_out_sim)
echo "$out"
if echo "$out" | grep -qF "All tests passed!"; then
	exit 0
fi
exit 1

/* second_if_out.f */
common/upconv_pkg.sv
common/seq_pkg.sv
common/lo_pair_if.sv
src/upconv_ctrl.sv
lo_gen/quarter_lo_rotator.sv
lo_gen/table_lo_mixer.sv
src/iq_interp.sv
src/level_mixer.sv
src/second_if_out.sv
verification/tb_clock.sv
verification/second_if_out_tb.sv

/* src/iq_interp.sv */
`timescale 1ns/1ns

module iq_interp (
	input  logic                clk,
	input  logic                i_rst_n,
	input  upconv_pkg::sample_t i_drive,
	input  logic                i_iq_strobe,
	output upconv_pkg::iq_t     o_i,
	output upconv_pkg::iq_t     o_q
);

	// Held I and Q, top 16 bits of the drive word
	logic signed [15:0] i_hold, q_hold;
	// Two consecutive held values per stream
	logic signed [15:0] i_d1, i_d2, q_d1, q_d2;

	always_ff @(posedge clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			i_hold <= '0;
			q_hold <= '0;
			i_d1   <= '0;
			i_d2   <= '0;
			q_d1   <= '0;
			q_d2   <= '0;
			o_i    <= '0;
			o_q    <= '0;
		end else begin
			// Stage 1, I on strobe low and Q on strobe high
			if (!i_iq_strobe)
				i_hold <= i_drive[17:2];
			else
				q_hold <= i_drive[17:2];
			// Stage 2
			i_d1 <= i_hold;
			i_d2 <= i_d1;
			q_d1 <= q_hold;
			q_d2 <= q_d1;
			// Stage 3, sum of neighbours is the average with one extra bit
			o_i <= upconv_pkg::iq_t'(i_d1) + upconv_pkg::iq_t'(i_d2);
			o_q <= upconv_pkg::iq_t'(q_d1) + upconv_pkg::iq_t'(q_d2);
		end
	end

endmodule

/* src/level_mixer.sv */
`timescale 1ns/1ns

module level_mixer (
	input  logic                clk,
	input  logic                i_rst_n,
	input  upconv_pkg::iq_t     i_i,
	input  upconv_pkg::iq_t     i_q,
	input  upconv_pkg::sample_t i_cos,
	input  upconv_pkg::sample_t i_sin,
	output upconv_pkg::dac_t    o_data
);

	logic signed [35:0] prod_c;
	logic signed [35:0] prod_s;
	logic signed [35:0] diff;
	logic signed [18:0] scaled;
	upconv_pkg::dac_t   sat;

	// Real part of (i + jq)(cos + j sin)
	assign prod_c = i_i * i_cos;
	assign prod_s = i_q * i_sin;
	assign diff   = prod_c - prod_s;
	assign scaled = 19'(diff >>> upconv_pkg::MIX_SHIFT);

	// Clip to +/-32767, most negative code never produced
	always_comb begin
		if (scaled > upconv_pkg::DAC_MAX)
			sat = upconv_pkg::dac_t'(upconv_pkg::DAC_MAX);
		else if (scaled < upconv_pkg::DAC_MIN)
			sat = upconv_pkg::dac_t'(upconv_pkg::DAC_MIN);
		else
			sat = upconv_pkg::dac_t'(scaled);
	end

	always_ff @(posedge clk or negedge i_rst_n) begin
		if (!i_rst_n)
			o_data <= '0;
		else
			o_data <= sat;
	end

	a_sym_sat: assert property (@(posedge clk) disable iff (!i_rst_n)
		o_data != {1'b1, {(upconv_pkg::DAC_W-1){1'b0}}});

endmodule

/* src/second_if_out.sv */
`timescale 1ns/1ns

module second_if_out (
	input  logic                clk,
	input  logic                i_rst_n,
	input  upconv_pkg::sample_t i_drive,
	input  logic [1:0]          i_div_state,
	input  logic                i_lo_sel,
	input  logic                i_enable,
	input  upconv_pkg::sample_t i_cosa,
	input  upconv_pkg::sample_t i_sina,
	output upconv_pkg::dac_t    o_dac1_out0,
	output upconv_pkg::dac_t    o_dac1_out1,
	output upconv_pkg::dac_t    o_dac2_out0,
	output upconv_pkg::dac_t    o_dac2_out1
);

	logic                 iq_strobe;
	seq_pkg::div_phase_e  phase;
	logic [5:0]           lut_addr;
	upconv_pkg::lo_mode_e mode;
	logic                 out_en;
	upconv_pkg::iq_t      drive_i, drive_q;
	upconv_pkg::dac_t     mix1, mix2;

	lo_pair_if rot_lo ();
	lo_pair_if tab_lo ();
	lo_pair_if sel_lo ();

	upconv_ctrl u_ctrl (
		.clk(clk), .i_rst_n(i_rst_n),
		.i_div_state(seq_pkg::div_phase_e'(i_div_state)),
		.i_lo_sel(i_lo_sel), .i_enable(i_enable),
		.o_iq_strobe(iq_strobe), .o_phase(phase), .o_lut_addr(lut_addr),
		.o_mode(mode), .o_out_en(out_en)
	);

	// Drive to full-rate I and Q
	iq_interp u_interp (
		.clk(clk), .i_rst_n(i_rst_n), .i_drive(i_drive),
		.i_iq_strobe(iq_strobe), .o_i(drive_i), .o_q(drive_q)
	);

	// ------------------------------------------------------------
	// LO generation, both paths run all the time
	// ------------------------------------------------------------
	quarter_lo_rotator u_rot (
		.clk(clk), .i_rst_n(i_rst_n), .i_phase(phase),
		.i_cosa(i_cosa), .i_sina(i_sina), .lo(rot_lo.src)
	);

	table_lo_mixer u_tab (
		.clk(clk), .i_rst_n(i_rst_n), .i_lut_addr(lut_addr),
		.i_cosa(i_cosa), .i_sina(i_sina), .lo(tab_lo.src)
	);

	// Registered LO select
	always_ff @(posedge clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			sel_lo.cos1 <= '0;
			sel_lo.sin1 <= '0;
			sel_lo.cos2 <= '0;
			sel_lo.sin2 <= '0;
		end else if (mode == upconv_pkg::LO_60) begin
			sel_lo.cos1 <= tab_lo.cos1;
			sel_lo.sin1 <= tab_lo.sin1;
			sel_lo.cos2 <= tab_lo.cos2;
			sel_lo.sin2 <= tab_lo.sin2;
		end else begin
			sel_lo.cos1 <= rot_lo.cos1;
			sel_lo.sin1 <= rot_lo.sin1;
			sel_lo.cos2 <= rot_lo.cos2;
			sel_lo.sin2 <= rot_lo.sin2;
		end
	end

	// ------------------------------------------------------------
	// IQ mixing, one mixer per DDR half
	// ------------------------------------------------------------
	level_mixer u_mix1 (
		.clk(clk), .i_rst_n(i_rst_n), .i_i(drive_i), .i_q(drive_q),
		.i_cos(sel_lo.cos1), .i_sin(sel_lo.sin1), .o_data(mix1)
	);

	level_mixer u_mix2 (
		.clk(clk), .i_rst_n(i_rst_n), .i_i(drive_i), .i_q(drive_q),
		.i_cos(sel_lo.cos2), .i_sin(sel_lo.sin2), .o_data(mix2)
	);

	// Muted during flush or when disabled
	assign o_dac1_out0 = out_en ? mix1 : '0;
	assign o_dac1_out1 = out_en ? mix2 : '0;
	// DAC2 unused, pin compatible
	assign o_dac2_out0 = '0;
	assign o_dac2_out1 = '0;

endmodule

/* src/upconv_ctrl.sv */
`timescale 1ns/1ns

module upconv_ctrl (
	input  logic                 clk,
	input  logic                 i_rst_n,
	input  seq_pkg::div_phase_e  i_div_state,
	input  logic                 i_lo_sel,
	input  logic                 i_enable,
	output logic                 o_iq_strobe,
	output seq_pkg::div_phase_e  o_phase,
	output logic [5:0]           o_lut_addr,
	output upconv_pkg::lo_mode_e o_mode,
	output logic                 o_out_en
);

	typedef enum logic {
		RUN   = 1'b0,
		FLUSH = 1'b1
	} state_e;

	state_e               state;
	logic [2:0]           flush_cnt;
	upconv_pkg::lo_mode_e mode_q;
	logic                 en_q;
	seq_pkg::div_phase_e  phase_q;
	logic [5:0]           lut_addr;
	logic [1:0]           phase_next;
	logic                 mode_change;

	// New mode differs from the registered one
	assign mode_change = (upconv_pkg::lo_mode_e'(i_lo_sel) != mode_q);
	assign phase_next  = phase_q + 2'd1;

	always_ff @(posedge clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			state     <= FLUSH;
			flush_cnt <= 3'(seq_pkg::FLUSH_CYCLES - 1);
			mode_q    <= upconv_pkg::LO_145;
			en_q      <= 1'b0;
			phase_q   <= seq_pkg::PH0;
			lut_addr  <= '0;
		end else begin
			mode_q   <= upconv_pkg::lo_mode_e'(i_lo_sel);
			en_q     <= i_enable;
			phase_q  <= i_div_state;
			// Modulo-33 table address, one step per clock
			lut_addr <= (lut_addr == 6'(seq_pkg::LUT_LAST)) ? 6'd0 : lut_addr + 6'd1;
			// Mode change restarts the mute window
			if (mode_change) begin
				state     <= FLUSH;
				flush_cnt <= 3'(seq_pkg::FLUSH_CYCLES - 1);
			end else if (state == FLUSH) begin
				if (flush_cnt == 3'd0)
					state <= RUN;
				else
					flush_cnt <= flush_cnt - 3'd1;
			end
		end
	end

	assign o_iq_strobe = phase_q[0];
	assign o_phase     = phase_q;
	assign o_lut_addr  = lut_addr;
	assign o_mode      = mode_q;
	// Muted while flushing or disabled
	assign o_out_en    = (state == RUN) && en_q;

	// ------------------------------------------------------------
	// Checks
	// ------------------------------------------------------------
	a_lut_range: assert property (@(posedge clk) disable iff (!i_rst_n)
		lut_addr <= 6'(seq_pkg::LUT_LAST));

	// Divider state from outside must be a free-running count
	a_phase_step: assert property (@(posedge clk) disable iff (!i_rst_n)
		$past(i_rst_n, 2) |-> (phase_q == $past(phase_next)));

endmodule

/* verification/second_if_out_tb.sv */
`timescale 1ns/1ns

module second_if_out_tb;

	localparam int N_ROWS  = 10;
	localparam int MAX_CYC = 512;
	localparam int LUT_N   = seq_pkg::LUT_LAST + 1;

	// One stimulus row, LO given as amplitude and phase in degrees
	typedef struct {
		int drive;
		bit rand_drive;
		int amp;
		int phase_deg;
		bit lo_sel;
		bit enable;
		int hold;
	} row_t;

	logic                clk;
	logic                rst_n;
	upconv_pkg::sample_t drive, cosa, sina;
	logic [1:0]          div_state;
	logic                lo_sel, enable;
	upconv_pkg::dac_t    dac1_out0, dac1_out1, dac2_out0, dac2_out1;

	row_t rows [N_ROWS];
	int   tab_cos [2][LUT_N];
	int   tab_sin [2][LUT_N];
	// Inputs as sampled on each rising edge, index 0 stands for reset
	int   h_drive [MAX_CYC];
	int   h_div [MAX_CYC];
	int   h_sel [MAX_CYC];
	int   h_en [MAX_CYC];
	int   h_cos [MAX_CYC];
	int   h_sin [MAX_CYC];
	// Held I and Q words and remaining mute clocks after each edge
	int   hold_i [MAX_CYC];
	int   hold_q [MAX_CYC];
	int   remain [MAX_CYC];
	int   edge_n, row_cos, row_sin;
	int   n_checks, n_errors;
	int   cycle_cnt, timeout_limit;

	tb_clock clock_i (
		.clk(clk),
		.o_rst_n(rst_n)
	);

	second_if_out dut_i (
		.clk(clk), .i_rst_n(rst_n), .i_drive(drive), .i_div_state(div_state),
		.i_lo_sel(lo_sel), .i_enable(enable), .i_cosa(cosa), .i_sina(sina),
		.o_dac1_out0(dac1_out0), .o_dac1_out1(dac1_out1),
		.o_dac2_out0(dac2_out0), .o_dac2_out1(dac2_out1)
	);

	// ------------------------------------------------------------
	// Reference model
	// ------------------------------------------------------------
	function automatic int round_real(input real v);
		return (v >= 0.0) ? $rtoi(v + 0.5) : $rtoi(v - 0.5);
	endfunction

	// Low 18 bits, as an 18-bit register keeps them
	function automatic int to_sample(input int x);
		upconv_pkg::sample_t t;
		t = upconv_pkg::sample_t'(x);
		return int'(t);
	endfunction

	// Table phasor, 14 cycles per 33 entries, second half offset by half a sample
	function automatic int lut_entry(input int half, input int k, input bit want_sin);
		real ang;
		ang = seq_pkg::TWO_PI * seq_pkg::LUT_STEP * (k + 0.5 * half) / LUT_N;
		return round_real((want_sin ? $sin(ang) : $cos(ang)) * upconv_pkg::LUT_AMP);
	endfunction

	// Real or imaginary part of phasor times LO, scaled to 18 bits and clipped
	function automatic int table_product(input int tc, input int ts, input int lc,
	                                     input int ls, input bit imag);
		longint acc;
		if (imag)
			acc = longint'(tc) * ls + longint'(ts) * lc;
		else
			acc = longint'(tc) * lc - longint'(ts) * ls;
		acc = acc >>> upconv_pkg::LO_SHIFT;
		if (acc > upconv_pkg::SAMPLE_MAX)
			acc = upconv_pkg::SAMPLE_MAX;
		if (acc < upconv_pkg::SAMPLE_MIN)
			acc = upconv_pkg::SAMPLE_MIN;
		return int'(acc);
	endfunction

	// i*cos - q*sin, shifted and clipped to the symmetric 16-bit range
	function automatic upconv_pkg::dac_t mix_level(input int iv, input int qv,
	                                              input int cv, input int sv);
		longint acc;
		acc = longint'(iv) * cv - longint'(qv) * sv;
		acc = acc >>> upconv_pkg::MIX_SHIFT;
		if (acc > upconv_pkg::DAC_MAX)
			acc = upconv_pkg::DAC_MAX;
		if (acc < upconv_pkg::DAC_MIN)
			acc = upconv_pkg::DAC_MIN;
		return upconv_pkg::dac_t'(acc);
	endfunction

	// LO pair at the mixers for edge m, from the LO sampled three edges earlier
	task automatic expected_lo(input int m, output int c1, output int s1,
	                           output int c2, output int s2);
		int e, cb, sb, addr;
		e = m - 3;
		if (h_sel[m - 2] != 0) begin
			addr = (m - 4) % LUT_N;
			c1 = table_product(tab_cos[0][addr], tab_sin[0][addr], h_cos[e], h_sin[e], 1'b0);
			s1 = table_product(tab_cos[0][addr], tab_sin[0][addr], h_cos[e], h_sin[e], 1'b1);
			c2 = table_product(tab_cos[1][addr], tab_sin[1][addr], h_cos[e], h_sin[e], 1'b0);
			s2 = table_product(tab_cos[1][addr], tab_sin[1][addr], h_cos[e], h_sin[e], 1'b1);
		end else begin
			// Times j^phase, negation is one's complement
			cb = h_cos[e];
			sb = h_sin[e];
			if (h_div[e - 1] == 1) begin
				cb = -h_sin[e] - 1;
				sb = h_cos[e];
			end else if (h_div[e - 1] == 2) begin
				cb = -h_cos[e] - 1;
				sb = -h_sin[e] - 1;
			end else if (h_div[e - 1] == 3) begin
				cb = h_sin[e];
				sb = -h_cos[e] - 1;
			end
			c1 = to_sample(cb - (sb >>> 4));
			s1 = to_sample(sb + (cb >>> 4));
			c2 = to_sample(-sb - 1 + (cb >>> 4));
			s2 = to_sample(cb + (sb >>> 4));
		end
	endtask

	// ------------------------------------------------------------
	// Compare tasks
	// ------------------------------------------------------------
	task automatic check_dac(input string name, input upconv_pkg::dac_t exp_v,
	                         input upconv_pkg::dac_t got);
		n_checks++;
		if (got !== exp_v) begin
			n_errors++;
			$display("error: time %0t %s expected %0d got %0d", $time, name, exp_v, got);
		end
	endtask

	// Both DAC1 words must be zero inside a mute window
	task automatic check_mode_flush(input upconv_pkg::lo_mode_e mode,
	                                input upconv_pkg::dac_t out0, input upconv_pkg::dac_t out1);
		n_checks++;
		if (out0 !== 16'sd0 || out1 !== 16'sd0) begin
			n_errors++;
			$display("error: time %0t o_dac1_out0/o_dac1_out1 in %s flush expected 0/0 got %0d/%0d",
			         $time, mode.name(), out0, out1);
		end
	endtask

	// Drive inputs for the next edge and log what that edge samples
	task automatic apply_inputs(input int r);
		int e;
		e = edge_n + 1;
		drive     = rows[r].rand_drive ? upconv_pkg::sample_t'($urandom)
		                               : upconv_pkg::sample_t'(rows[r].drive);
		cosa      = upconv_pkg::sample_t'(row_cos);
		sina      = upconv_pkg::sample_t'(row_sin);
		lo_sel    = rows[r].lo_sel;
		enable    = rows[r].enable;
		div_state = div_state + 2'd1;
		h_drive[e] = int'(drive);
		h_div[e]   = int'(div_state);
		h_sel[e]   = int'(lo_sel);
		h_en[e]    = int'(enable);
		h_cos[e]   = row_cos;
		h_sin[e]   = row_sin;
		// I is taken while the registered phase is even, Q while odd
		hold_i[e] = (h_div[e - 1] % 2 == 0) ? (h_drive[e] >>> 2) : hold_i[e - 1];
		hold_q[e] = (h_div[e - 1] % 2 == 1) ? (h_drive[e] >>> 2) : hold_q[e - 1];
		if (h_sel[e] != h_sel[e - 1])
			remain[e] = seq_pkg::FLUSH_CYCLES;
		else
			remain[e] = (remain[e - 1] > 0) ? remain[e - 1] - 1 : 0;
	endtask

	task automatic check_outputs(input int m);
		int c1, s1, c2, s2, di, dq;
		upconv_pkg::dac_t exp0, exp1;
		exp0 = '0;
		exp1 = '0;
		check_dac("o_dac2_out0", '0, dac2_out0);
		check_dac("o_dac2_out1", '0, dac2_out1);
		if (remain[m] > 0) begin
			check_mode_flush(upconv_pkg::lo_mode_e'(h_sel[m]), dac1_out0, dac1_out1);
		end else begin
			if (h_en[m] != 0) begin
				expected_lo(m, c1, s1, c2, s2);
				// Sum of two held words is the average with one extra bit
				di = hold_i[m - 3] + hold_i[m - 4];
				dq = hold_q[m - 3] + hold_q[m - 4];
				exp0 = mix_level(di, dq, c1, s1);
				exp1 = mix_level(di, dq, c2, s2);
			end
			check_dac("o_dac1_out0", exp0, dac1_out0);
			check_dac("o_dac1_out1", exp1, dac1_out1);
		end
	endtask

	// Watchdog
	always @(posedge clk) begin
		cycle_cnt = cycle_cnt + 1;
		if (timeout_limit > 0 && cycle_cnt >= timeout_limit) begin
			$display("timeout: run did not finish within %0d clocks", timeout_limit);
			$display("Test failures found");
			$finish;
		end
	end

	initial begin
		real rad;
		void'($urandom(32'h53edd3ca));
		drive     = '0;
		div_state = 2'd0;
		lo_sel    = 1'b0;
		enable    = 1'b0;
		cosa      = '0;
		sina      = '0;
		edge_n    = 0;
		n_checks  = 0;
		n_errors  = 0;
		cycle_cnt = 0;
		remain[0] = seq_pkg::FLUSH_CYCLES;
		// drive, random drive, LO amplitude, phase, lo_sel, enable, hold
		rows[0] = '{0, 1'b1, 100000, 30, 1'b0, 1'b0, 8};
		rows[1] = '{0, 1'b1, 90000, 60, 1'b0, 1'b1, 12};
		rows[2] = '{0, 1'b1, 120000, 200, 1'b0, 1'b1, 12};
		rows[3] = '{0, 1'b1, 100000, 10, 1'b1, 1'b1, 40};
		rows[4] = '{74565, 1'b0, 70000, 300, 1'b1, 1'b1, 10};
		rows[5] = '{0, 1'b1, 80000, 45, 1'b1, 1'b0, 6};
		rows[6] = '{131071, 1'b0, 131071, 0, 1'b0, 1'b1, 10};
		rows[7] = '{-131072, 1'b0, 131071, 180, 1'b0, 1'b1, 10};
		rows[8] = '{131071, 1'b0, 131071, 90, 1'b1, 1'b1, 12};
		rows[9] = '{0, 1'b1, 50000, 135, 1'b0, 1'b1, 10};
		timeout_limit = 50;
		for (int r = 0; r < N_ROWS; r++)
			timeout_limit += rows[r].hold;
		for (int h = 0; h < 2; h++) begin
			for (int k = 0; k < LUT_N; k++) begin
				tab_cos[h][k] = lut_entry(h, k, 1'b0);
				tab_sin[h][k] = lut_entry(h, k, 1'b1);
			end
		end
		wait (rst_n === 1'b1);
		for (int r = 0; r < N_ROWS; r++) begin
			rad     = seq_pkg::TWO_PI * rows[r].phase_deg / 360.0;
			row_cos = round_real(rows[r].amp * $cos(rad));
			row_sin = round_real(rows[r].amp * $sin(rad));
			for (int k = 0; k < rows[r].hold; k++) begin
				apply_inputs(r);
				@(posedge clk);
				edge_n++;
				#5;
				check_outputs(edge_n);
			end
		end
		$display("checks %0d, errors %0d", n_checks, n_errors);
		if (n_errors == 0)
			$display("All tests passed!");
		else
			$display("Test failures found");
		$finish;
	end

endmodule

/* verification/tb_clock.sv */
`timescale 1ns/1ns

module tb_clock (
	output logic clk,
	output logic o_rst_n
);

	// 40 ns period
	localparam int HALF_PERIOD = 20;

	initial begin
		clk = 1'b0;
		forever #HALF_PERIOD clk = ~clk;
	end

	// Low for two rising edges, released clear of the edge
	initial begin
		o_rst_n = 1'b0;
		repeat (2) @(posedge clk);
		#5;
		o_rst_n = 1'b1;
	end

endmodule
